//--- list.f
src/albuf_pkg.sv
src/fetch_ctrl.sv
src/resp_fifo.sv
src/instr_aligner.sv
src/alignment_buffer.sv
tb/tb_alignment_buffer.sv

//--- run.sh
#!/bin/sh
# Build and run the alignment buffer testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_alignment_buffer \
  -Mdir obj_dir -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1 || echo "build or run failed"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

//--- src/albuf_pkg.sv
// Shared types for the alignment buffer; responses must return in request order, at most two in flight
package albuf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Control and data structs
  ////////////////////////////////////////////////////////////////////////////

  // Control from the core, kill has priority over the other fields
  typedef struct packed {
    logic instr_req;
    logic pc_set;
    logic kill;
  } albuf_ctrl_t;

  // One bus response word as returned by the prefetcher
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fetch_resp_t;

  // One emitted instruction
  // Upper half carries whatever follows a compressed instruction
  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } instr_out_t;

  // Fetch requests allowed in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Ring depth in words, three is the smallest that works
  localparam int unsigned ALBUF_DEPTH_DEFAULT = 3;

  // A halfword starts a 16-bit instruction unless both low bits are set
  function automatic logic is_compressed(input logic [1:0] lsb);
    return lsb != 2'b11;
  endfunction

endpackage

//--- src/alignment_buffer.sv
// Alignment buffer top; the response port has no back-pressure and must always be accepted
`timescale 1ns/100ps
module alignment_buffer import albuf_pkg::*; #(
  parameter int unsigned DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  albuf_ctrl_t ctrl_i,
  input  logic [31:0] branch_addr_i,
  output logic        fetch_valid_o,
  input  logic        fetch_ready_i,
  output logic        fetch_branch_o,
  output logic [31:0] fetch_branch_addr_o,
  input  logic        resp_valid_i,
  input  fetch_resp_t resp_i,
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output instr_out_t  instr_o,
  output logic [31:0] instr_addr_o,
  output logic        protocol_err_o
);

  // Gated response strobe, low while flushing
  logic        resp_write;
  fetch_resp_t head_entry, next_entry;
  logic        head_valid, next_valid;
  logic        fifo_advance, fifo_release, instr_pop;

  fetch_ctrl #(.DEPTH(DEPTH)) u_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_i              (ctrl_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_ready_i       (fetch_ready_i),
    .resp_valid_i        (resp_valid_i),
    .resp_i              (resp_i),
    .pop_i               (instr_pop),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_write_o        (resp_write),
    .protocol_err_o      (protocol_err_o)
  );

  resp_fifo #(.DEPTH(DEPTH)) u_resp_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .kill_i       (ctrl_i.kill),
    .branch_i     (ctrl_i.pc_set),
    .write_i      (resp_write),
    .resp_i       (resp_i),
    .advance_i    (fifo_advance),
    .release_i    (fifo_release),
    .head_o       (head_entry),
    .next_o       (next_entry),
    .head_valid_o (head_valid),
    .next_valid_o (next_valid)
  );

  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (ctrl_i.kill),
    .branch_i      (ctrl_i.pc_set),
    .branch_addr_i (branch_addr_i),
    .resp_valid_i  (resp_write),
    .resp_i        (resp_i),
    .head_i        (head_entry),
    .next_i        (next_entry),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .advance_o     (fifo_advance),
    .release_o     (fifo_release),
    .pop_o         (instr_pop)
  );

endmodule

//--- src/fetch_ctrl.sv
// Fetch request control; counts complete instructions written, so DEPTH must be 3 or more
`timescale 1ns/100ps
module fetch_ctrl import albuf_pkg::*; #(
  parameter int unsigned DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  albuf_ctrl_t ctrl_i,
  input  logic [31:0] branch_addr_i,
  input  logic        fetch_ready_i,
  input  logic        resp_valid_i,
  input  fetch_resp_t resp_i,
  input  logic        pop_i,
  output logic        fetch_valid_o,
  output logic        fetch_branch_o,
  output logic [31:0] fetch_branch_addr_o,
  output logic        resp_write_o,
  output logic        protocol_err_o
);

  // Up to two instructions per word
  localparam int unsigned CNT_W = $clog2(2 * DEPTH + 1);
  localparam int unsigned OUT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [OUT_W-1:0] out_q, out_n, flush_q, flush_n;
  logic [CNT_W-1:0] cnt_q, cnt_n, cnt_eff;
  logic [1:0]       n_incoming;
  logic             aligned_q, aligned_n, complete_q, complete_n;
  logic             pop_q, req_acc, resp_ok, restart;
  logic             lo_c, hi_c;

  // Kill or branch drops everything still on the way back
  assign restart = ctrl_i.pc_set || ctrl_i.kill;
  assign req_acc = fetch_valid_o && fetch_ready_i;
  assign resp_ok = resp_valid_i && (out_q != '0);
  assign resp_write_o = resp_valid_i && (flush_q == '0);
  assign protocol_err_o = resp_valid_i && (out_q == '0);

  // Pop from last cycle is still in cnt_q
  assign cnt_eff = cnt_q - CNT_W'(pop_q);

  assign fetch_valid_o = ctrl_i.instr_req && (ctrl_i.pc_set || !ctrl_i.kill) &&
                         (out_q < OUT_W'(MAX_OUTSTANDING)) &&
                         ((cnt_eff == '0) || ((cnt_eff == CNT_W'(1)) && (out_q == '0)) ||
                          ctrl_i.pc_set);

  assign fetch_branch_o      = ctrl_i.pc_set;
  assign fetch_branch_addr_o = {branch_addr_i[31:1], 1'b0};

  assign lo_c = is_compressed(resp_i.rdata[1:0]);
  assign hi_c = is_compressed(resp_i.rdata[17:16]);

  ////////////////////////////////////////////////////////////////////////////
  // Write side alignment and instruction count
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (ctrl_i.pc_set) begin
      // Halfword target, lower half of the first word is skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_write_o && !ctrl_i.kill) begin
      if (aligned_q) begin
        if (!lo_c) begin
          n_incoming = 2'd1;
        end else if (!hi_c) begin
          // Compressed low, 32-bit starts in upper half
          n_incoming = 2'd1;
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end else begin
          n_incoming = 2'd2;
        end
      end else begin
        // complete_q set here only right after a halfword branch
        // Otherwise the lower half ends a straddling instruction
        n_incoming = complete_q ? 2'd0 : 2'd1;
        if (hi_c) begin
          n_incoming = n_incoming + 2'd1;
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end else begin
          complete_n = 1'b0;
        end
      end
    end
  end

  always_comb begin
    cnt_n = restart ? '0 : cnt_q + CNT_W'(n_incoming) - CNT_W'(pop_q);
    // Outstanding requests, a stray response does not underflow
    out_n = out_q + OUT_W'(req_acc) - OUT_W'(resp_ok);
    flush_n = flush_q;
    if (restart) begin
      flush_n = out_q - OUT_W'(resp_ok);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - OUT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q      <= '0;
      flush_q    <= '0;
      cnt_q      <= '0;
      pop_q      <= 1'b0;
      aligned_q  <= 1'b1;
      complete_q <= 1'b1;
    end else begin
      out_q      <= out_n;
      flush_q    <= flush_n;
      cnt_q      <= cnt_n;
      pop_q      <= pop_i && !restart;
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
    end
  end

  // Responses still to be dropped never outnumber those in flight
  a_flush_in_flight : assert property (@(posedge clk) disable iff (!rst_n)
    flush_q <= out_q);

endmodule

//--- src/instr_aligner.sv
// Instruction cutter; head of the ring is always the word holding instr_addr_o, and responses bypass
`timescale 1ns/100ps
module instr_aligner import albuf_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        kill_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  input  logic        resp_valid_i,
  input  fetch_resp_t resp_i,
  input  fetch_resp_t head_i,
  input  fetch_resp_t next_i,
  input  logic        head_valid_i,
  input  logic        next_valid_i,
  input  logic        instr_ready_i,
  output logic        instr_valid_o,
  output instr_out_t  instr_o,
  output logic [31:0] instr_addr_o,
  output logic        advance_o,
  output logic        release_o,
  output logic        pop_o
);

  logic [31:0] addr_q, addr_n, addr_incr;
  fetch_resp_t word_a, word_b;
  logic        avail, avail_split, compr, leave_word, xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////////////////////////////////////////

  // Word holding the current address, from the ring or straight off the bus
  assign word_a = head_valid_i ? head_i : resp_i;
  // Following word, only read for the upper half of a straddling instruction
  assign word_b = next_valid_i ? next_i : resp_i;

  assign avail = head_valid_i || resp_valid_i;
  // Head present implied when next is valid
  assign avail_split = next_valid_i || (head_valid_i && resp_valid_i);

  assign compr = addr_q[1] ? is_compressed(word_a.rdata[17:16]) :
                             is_compressed(word_a.rdata[1:0]);

  always_comb begin
    instr_o.data  = word_a.rdata;
    instr_o.err   = word_a.err;
    instr_valid_o = avail;
    if (addr_q[1]) begin
      instr_o.data = {word_b.rdata[15:0], word_a.rdata[31:16]};
      if (!compr) begin
        // Straddling 32-bit, error from either word
        instr_o.err   = word_a.err || word_b.err;
        instr_valid_o = avail_split;
      end
    end
    // Old stream is dropped on kill or branch
    if (kill_i || branch_i) begin
      instr_valid_o = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address stepping
  ////////////////////////////////////////////////////////////////////////////

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;
  assign xfer      = instr_valid_o && instr_ready_i;

  always_comb begin
    addr_n     = addr_incr;
    leave_word = 1'b1;
    if (addr_q[1]) begin
      // Straddler ends halfway into the next word
      if (!compr) begin
        addr_n = {addr_incr[31:2], 2'b10};
      end
    end else if (compr) begin
      // Upper half of the same word is next
      addr_n     = {addr_q[31:2], 2'b10};
      leave_word = 1'b0;
    end
  end

  assign advance_o = xfer && leave_word;
  // Head entry is freed as the read pointer moves past it
  assign release_o = advance_o;
  assign pop_o     = xfer;
  assign instr_addr_o = addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= branch_addr_i;
    end else if (xfer) begin
      addr_q <= addr_n;
    end
  end

  // Ring holds no valid entry in the cycle after a kill
  a_kill_empties : assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |=> (!head_valid_i && !next_valid_i));

endmodule

//--- src/resp_fifo.sv
// Ring of response words; a write into a valid entry is a throttling bug upstream
`timescale 1ns/100ps
module resp_fifo import albuf_pkg::*; #(
  parameter int unsigned DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        kill_i,
  input  logic        branch_i,
  input  logic        write_i,
  input  fetch_resp_t resp_i,
  input  logic        advance_i,
  input  logic        release_i,
  output fetch_resp_t head_o,
  output fetch_resp_t next_o,
  output logic        head_valid_o,
  output logic        next_valid_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  fetch_resp_t      mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q, valid_n;
  logic [PTR_W-1:0] wptr_q, rptr_q, wptr_nxt, rptr_nxt;
  logic             flush;

  // Wrapping increment for a ring that need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Writes in a kill or branch cycle belong to the old stream
  assign flush    = kill_i || branch_i;
  assign wptr_nxt = ptr_inc(wptr_q);
  assign rptr_nxt = ptr_inc(rptr_q);

  assign head_o       = mem_q[rptr_q];
  assign next_o       = mem_q[rptr_nxt];
  assign head_valid_o = valid_q[rptr_q];
  assign next_valid_o = valid_q[rptr_nxt];

  // Set before clear, a bypassed word consumed at once never stays valid
  always_comb begin
    valid_n = valid_q;
    if (write_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (release_i) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (write_i && !flush) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
      if (branch_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end
    end else begin
      if (write_i) begin
        wptr_q <= wptr_nxt;
      end
      if (advance_i) begin
        rptr_q <= rptr_nxt;
      end
      valid_q <= valid_n;
    end
  end

  // Request throttling in fetch_ctrl keeps the ring from overflowing
  a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
    (write_i && !flush) |-> !valid_q[wptr_q]);

endmodule

//--- tb/albuf_tests.txt
# target bp mode errw nwords ncheck, all hex; mode 0 plain, 1 branch first, 2 kill first
# next line: nwords memory words from the target's word address; errw ff marks no error word
00001000 0 0 ff 4 4
00100093 00208113 003181b3 00420213
00002000 0 0 ff 4 6
05054501 00938082 45010010 00208113
00003002 0 0 ff 3 3
00934501 05050010 003181b3
00004000 1 1 ff 4 6
05054501 00938082 45010010 00208113
00005002 0 2 ff 3 4
80824501 00100093 45010505
00006000 1 0 ff 6 9
00100093 05054501 01138082 45010030 003181b3 80820505
00007000 0 0 1 3 4
00930505 45010010 00208113
00008002 1 1 0 3 3
01138082 45010030 00420213

//--- tb/tb_alignment_buffer.sv
// Testbench for the alignment buffer; reads tb/albuf_tests.txt, up to 16 tests of 16 words
`timescale 1ns/100ps
module tb_alignment_buffer import albuf_pkg::*; ();

  localparam int MAX_TESTS = 16;
  localparam int MAX_WORDS = 16;
  localparam int MAX_INSTR = 32;
  localparam int CLK_HALF  = 10;

  logic        clk, rst_n;
  albuf_ctrl_t ctrl;
  logic [31:0] branch_addr, fetch_branch_addr, instr_addr;
  logic        fetch_valid, fetch_ready, fetch_branch;
  logic        resp_valid, instr_valid, instr_ready, protocol_err;
  fetch_resp_t resp;
  instr_out_t  instr;

  // Test table as read from the data file
  logic [31:0] t_target [MAX_TESTS];
  logic        t_bp [MAX_TESTS];
  int          t_mode [MAX_TESTS], t_errw [MAX_TESTS];
  int          t_nwords [MAX_TESTS], t_ncheck [MAX_TESTS];
  logic [31:0] t_words [MAX_TESTS][MAX_WORDS];
  int          num_tests, total_instr, wd_cycles;
  logic        loaded;

  // Expected stream of the running test
  logic [31:0] exp_data [MAX_INSTR];
  logic [31:0] exp_addr [MAX_INSTR];
  logic        exp_err [MAX_INSTR];
  logic        exp_c [MAX_INSTR];

  // Memory responder, one entry per accepted request
  logic [31:0] req_addr_q [$];
  int          req_due_q [$];
  logic [31:0] next_fetch, base, hold_addr;
  logic        collecting, hold_prev;
  int          cur, got_cnt, cyc, errors, tests_run, tests_failed;
  integer      seed;

  alignment_buffer #(.DEPTH(ALBUF_DEPTH_DEFAULT)) u_alignment_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_i              (ctrl),
    .branch_addr_i       (branch_addr),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .instr_valid_o       (instr_valid),
    .instr_ready_i       (instr_ready),
    .instr_o             (instr),
    .instr_addr_o        (instr_addr),
    .protocol_err_o      (protocol_err)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // Image words inside the test range, a pattern of the full address outside
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    int idx;
    idx = int'((addr - base) >> 2);
    if (addr >= base && idx < t_nwords[cur]) begin
      return t_words[cur][idx];
    end
    return addr ^ 32'h9e37_79b9;
  endfunction

  function automatic logic mem_err(input logic [31:0] addr);
    int idx;
    idx = int'((addr - base) >> 2);
    return (addr >= base) && (idx < t_nwords[cur]) && (idx == t_errw[cur]);
  endfunction

  // Walk the image from the target, 2 or 4 bytes per instruction
  task automatic build_expected();
    logic [31:0] a, wa, w0, w1;
    logic [15:0] hw;
    int          k;
    a = t_target[cur];
    for (k = 0; k < t_ncheck[cur]; k++) begin
      wa = {a[31:2], 2'b00};
      w0 = mem_word(wa);
      w1 = mem_word(wa + 32'd4);
      hw = a[1] ? w0[31:16] : w0[15:0];
      exp_addr[k] = a;
      exp_c[k]    = hw[1:0] != 2'b11;
      if (exp_c[k]) begin
        exp_data[k] = {16'h0, hw};
        exp_err[k]  = mem_err(wa);
        a = a + 32'd2;
      end else begin
        // Straddler takes its upper half from the following word
        exp_data[k] = a[1] ? {w1[15:0], hw} : w0;
        exp_err[k]  = a[1] ? (mem_err(wa) | mem_err(wa + 32'd4)) : mem_err(wa);
        a = a + 32'd4;
      end
    end
  endtask

  task automatic report_value(input string sig, input logic [31:0] expv, input logic [31:0] gotv);
    $display("ERR test %0d instr %0d %s exp %h got %h", cur + 1, got_cnt, sig, expv, gotv);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle: drive on the falling edge, sample just before the rise
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic req, input logic set, input logic kill,
                           input logic [31:0] baddr, input logic bp);
    logic [31:0] ra, rnd;
    int          lat, k;
    @(negedge clk);
    ctrl.instr_req = req;
    ctrl.pc_set    = set;
    ctrl.kill      = kill;
    branch_addr    = baddr;
    rnd            = $random(seed);
    instr_ready    = bp ? rnd[0] : 1'b1;
    // Oldest request answers once its latency has run out
    if (req_addr_q.size() > 0 && req_due_q[0] <= cyc) begin
      ra = req_addr_q.pop_front();
      void'(req_due_q.pop_front());
      resp_valid = 1'b1;
      resp.rdata = mem_word(ra);
      resp.err   = mem_err(ra);
    end else begin
      resp_valid = 1'b0;
      resp       = '0;
    end
    #(CLK_HALF - 1);
    if (protocol_err !== 1'b0) begin
      $display("protocol_err_o raised for a response that was requested");
      errors++;
    end
    if ((kill || set) && instr_valid !== 1'b0) begin
      $display("instruction offered in a kill or branch cycle");
      errors++;
    end
    if (fetch_branch !== set) begin
      report_value("fetch_branch_o", {31'h0, set}, {31'h0, fetch_branch});
    end
    if (set && fetch_branch_addr !== {baddr[31:1], 1'b0}) begin
      report_value("fetch_branch_addr_o", {baddr[31:1], 1'b0}, fetch_branch_addr);
    end
    // Prefetcher restarts at the branch word
    if (fetch_branch) begin
      next_fetch = {fetch_branch_addr[31:2], 2'b00};
    end
    if (fetch_valid && fetch_ready) begin
      rnd = $random(seed);
      lat = 1 + int'({1'b0, rnd[30:0]} % 32'd3);
      req_addr_q.push_back(next_fetch);
      req_due_q.push_back(cyc + lat);
      next_fetch = next_fetch + 32'd4;
      if (req_addr_q.size() > int'(MAX_OUTSTANDING)) begin
        $display("more than two fetch requests in flight");
        errors++;
      end
    end
    // A stalled instruction stays put
    if (collecting && hold_prev) begin
      if (instr_valid !== 1'b1) begin
        $display("instruction withdrawn while instr_ready_i was low");
        errors++;
      end else if (instr_addr !== hold_addr) begin
        report_value("instr_addr_o", hold_addr, instr_addr);
      end
    end
    hold_prev = collecting && instr_valid && !instr_ready;
    hold_addr = instr_addr;
    if (collecting && instr_valid && instr_ready) begin
      k = got_cnt;
      if (instr_addr !== exp_addr[k]) begin
        report_value("instr_addr_o", exp_addr[k], instr_addr);
      end
      if (exp_c[k] && instr.data[15:0] !== exp_data[k][15:0]) begin
        report_value("instr_o.data", exp_data[k], {16'h0, instr.data[15:0]});
      end
      if (!exp_c[k] && instr.data !== exp_data[k]) begin
        report_value("instr_o.data", exp_data[k], instr.data);
      end
      if (instr.err !== exp_err[k]) begin
        report_value("instr_o.err", {31'h0, exp_err[k]}, {31'h0, instr.err});
      end
      got_cnt++;
    end
    cyc++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int          fd, code, k;
    string       line;
    logic [31:0] tg, bp, md, ew, nw, nc, w;
    num_tests   = 0;
    total_instr = 0;
    fd = $fopen("tb/albuf_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/albuf_tests.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip column notes and the ends of word lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h %h %h", tg, bp, md, ew, nw, nc);
          if (code == 6 && num_tests < MAX_TESTS && nw <= MAX_WORDS && nc <= MAX_INSTR) begin
            t_target[num_tests] = tg;
            t_bp[num_tests]     = bp[0];
            t_mode[num_tests]   = int'(md);
            t_errw[num_tests]   = int'(ew);
            t_nwords[num_tests] = int'(nw);
            t_ncheck[num_tests] = int'(nc);
            for (k = 0; k < int'(nw); k++) begin
              code = $fscanf(fd, "%h", w);
              t_words[num_tests][k] = w;
            end
            total_instr += int'(nc);
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_tests == 0) begin
      $display("no test records found in the data file");
      errors++;
    end
    wd_cycles = 40 * total_instr + 30 * num_tests + 100;
    loaded = 1'b1;
  endtask

  task automatic run_test();
    logic [31:0] tgt, decoy;
    logic        bp;
    int          err_start, limit, n;
    tgt        = t_target[cur];
    bp         = t_bp[cur];
    base       = {tgt[31:2], 2'b00};
    decoy      = tgt + 32'h100;
    err_start  = errors;
    got_cnt    = 0;
    collecting = 1'b0;
    hold_prev  = 1'b0;
    build_expected();
    // Start a stream elsewhere so responses are in flight at the real branch
    if (t_mode[cur] != 0) begin
      run_cycle(1'b1, 1'b1, 1'b0, decoy, bp);
      run_cycle(1'b1, 1'b0, 1'b0, decoy, bp);
    end
    if (t_mode[cur] == 2) begin
      run_cycle(1'b0, 1'b0, 1'b1, tgt, bp);
      run_cycle(1'b0, 1'b0, 1'b0, tgt, bp);
      if (instr_valid !== 1'b0) begin
        $display("instruction offered in the cycle after a kill");
        errors++;
      end
    end
    run_cycle(1'b1, 1'b1, 1'b0, tgt, bp);
    collecting = 1'b1;
    limit = 40 * t_ncheck[cur];
    n = 0;
    while (got_cnt < t_ncheck[cur] && n < limit) begin
      run_cycle(1'b1, 1'b0, 1'b0, tgt, bp);
      n++;
    end
    collecting = 1'b0;
    if (got_cnt < t_ncheck[cur]) begin
      $display("only %0d of %0d instructions arrived in time", got_cnt, t_ncheck[cur]);
      errors++;
    end
    tests_run++;
    if (errors == err_start) begin
      $display("test %0d ok, %0d instructions from %h", cur + 1, got_cnt, tgt);
    end else begin
      $display("test %0d failed with %0d errors", cur + 1, errors - err_start);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] rnd;
    int          err_start;
    seed         = 32'h745d940b;
    rst_n        = 1'b0;
    ctrl         = '0;
    branch_addr  = '0;
    fetch_ready  = 1'b1;
    resp_valid   = 1'b0;
    resp         = '0;
    instr_ready  = 1'b0;
    loaded       = 1'b0;
    collecting   = 1'b0;
    hold_prev    = 1'b0;
    hold_addr    = '0;
    next_fetch   = '0;
    base         = '0;
    cur          = 0;
    got_cnt      = 0;
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_tests();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset, then a response nobody asked for
    err_start = errors;
    run_cycle(1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    if (fetch_valid !== 1'b0 || instr_valid !== 1'b0) begin
      $display("fetch or instruction valid raised while idle after reset");
      errors++;
    end
    @(negedge clk);
    rnd         = $random(seed);
    instr_ready = 1'b0;
    resp_valid  = 1'b1;
    resp.rdata  = rnd;
    resp.err    = 1'b0;
    #(CLK_HALF - 1);
    if (protocol_err !== 1'b1) begin
      report_value("protocol_err_o", 32'h1, {31'h0, protocol_err});
    end
    cyc++;
    tests_run++;
    if (errors == err_start) begin
      $display("reset test ok");
    end else begin
      $display("reset test failed");
      tests_failed++;
    end

    for (cur = 0; cur < num_tests; cur++) begin
      run_test();
    end

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the instruction count of all tests
  initial begin
    wait (loaded);
    #(wd_cycles * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
